//--- build.f
mips_pkg.sv
id_ex_if.sv
register_file.sv
decode_stage.sv
id_ex.sv
execute_stage.sv
datapath_top.sv
tb_clock_gen.sv
tb_datapath.sv

//--- datapath_top.sv
`timescale 1ns/1ps

module datapath_top (
	input  logic            clk,
	input  logic            reset_n,
	input  mips_pkg::word_t instr,
	input  mips_pkg::word_t pc_plus4,
	input  mips_pkg::word_t load_data,
	output mips_pkg::word_t alu_result,
	output mips_pkg::word_t mem_addr,
	output mips_pkg::word_t mem_wdata,
	output logic            mem_read,
	output logic            mem_write,
	output logic            branch_taken,
	output mips_pkg::word_t branch_target
);

	logic wb_en;
	mips_pkg::reg_addr_t wb_addr;
	mips_pkg::word_t wb_data;

	id_ex_if dec_bus ();
	id_ex_if ex_bus ();

	decode_stage u_decode_stage (
		.clk      (clk),
		.reset_n  (reset_n),
		.instr    (instr),
		.pc_plus4 (pc_plus4),
		.dec_bus  (dec_bus.source),
		.wb_en    (wb_en),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data)
	);

	id_ex u_id_ex (
		.clk     (clk),
		.reset_n (reset_n),
		.dec_bus (dec_bus.sink),
		.ex_bus  (ex_bus.source)
	);

	// writeback loops back into decode.
	execute_stage u_execute_stage (
		.ex_bus        (ex_bus.sink),
		.load_data     (load_data),
		.alu_result    (alu_result),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.wb_en         (wb_en),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data)
	);

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                clk,
	input  logic                reset_n,
	input  mips_pkg::word_t     instr,
	input  mips_pkg::word_t     pc_plus4,
	id_ex_if.source             dec_bus,
	input  logic                wb_en,
	input  mips_pkg::reg_addr_t wb_addr,
	input  mips_pkg::word_t     wb_data
);

	mips_pkg::word_t if_id_instr;
	mips_pkg::word_t if_id_pc;
	logic [5:0] opcode;
	logic [5:0] funct;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	mips_pkg::ctrl_t ctrl;
	mips_pkg::word_t rs_data;
	mips_pkg::word_t rt_data;

	// if/id register.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			if_id_instr <= '0;
			if_id_pc <= '0;
		end else begin
			if_id_instr <= instr;
			if_id_pc <= pc_plus4;
		end
	end

	assign opcode = if_id_instr[31:26];
	assign funct = if_id_instr[5:0];
	assign rs = if_id_instr[25:21];
	assign rt = if_id_instr[20:16];
	assign rd = if_id_instr[15:11];

	// main control unit.
	always_comb begin
		ctrl = '0;
		case (opcode)
			mips_pkg::op_rtype: begin
				// unsupported funct codes stay a bubble.
				if ((funct == mips_pkg::fn_add) || (funct == mips_pkg::fn_sub) ||
					(funct == mips_pkg::fn_and) || (funct == mips_pkg::fn_or) ||
					(funct == mips_pkg::fn_slt)) begin
					ctrl.reg_write = 1'b1;
					ctrl.reg_dest = 1'b1;
					ctrl.alu_op = mips_pkg::alu_op_funct;
				end
			end
			mips_pkg::op_lw: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = mips_pkg::alu_op_add;
			end
			mips_pkg::op_sw: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = mips_pkg::alu_op_add;
			end
			mips_pkg::op_beq: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = mips_pkg::alu_op_sub;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

	register_file u_register_file (
		.clk     (clk),
		.reset_n (reset_n),
		.rs_addr (rs),
		.rt_addr (rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

	assign dec_bus.ctrl = ctrl;
	assign dec_bus.next_pc = if_id_pc;
	assign dec_bus.read_data_1 = rs_data;
	assign dec_bus.read_data_2 = rt_data;
	assign dec_bus.ext_offset = {{16{if_id_instr[15]}}, if_id_instr[15:0]};
	assign dec_bus.rt = rt;
	assign dec_bus.rd = rd;

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	id_ex_if.sink               ex_bus,
	input  mips_pkg::word_t     load_data,
	output mips_pkg::word_t     alu_result,
	output mips_pkg::word_t     mem_addr,
	output mips_pkg::word_t     mem_wdata,
	output logic                mem_read,
	output logic                mem_write,
	output logic                branch_taken,
	output mips_pkg::word_t     branch_target,
	output logic                wb_en,
	output mips_pkg::reg_addr_t wb_addr,
	output mips_pkg::word_t     wb_data
);

	mips_pkg::alu_ctrl_t alu_ctrl;
	mips_pkg::word_t alu_a;
	mips_pkg::word_t alu_b;
	mips_pkg::word_t result;
	logic [5:0] funct;
	logic zero;

	// funct sits in the low bits of the offset field.
	assign funct = ex_bus.ext_offset[5:0];

	// alu control.
	always_comb begin
		case (ex_bus.ctrl.alu_op)
			mips_pkg::alu_op_add: alu_ctrl = mips_pkg::alu_add;
			mips_pkg::alu_op_sub: alu_ctrl = mips_pkg::alu_sub;
			default: begin
				case (funct)
					mips_pkg::fn_add: alu_ctrl = mips_pkg::alu_add;
					mips_pkg::fn_sub: alu_ctrl = mips_pkg::alu_sub;
					mips_pkg::fn_or:  alu_ctrl = mips_pkg::alu_or;
					mips_pkg::fn_slt: alu_ctrl = mips_pkg::alu_slt;
					default:          alu_ctrl = mips_pkg::alu_and;
				endcase
			end
		endcase
	end

	assign alu_a = ex_bus.read_data_1;
	assign alu_b = ex_bus.ctrl.alu_src ? ex_bus.ext_offset : ex_bus.read_data_2;

	always_comb begin
		case (alu_ctrl)
			mips_pkg::alu_and: result = alu_a & alu_b;
			mips_pkg::alu_or:  result = alu_a | alu_b;
			mips_pkg::alu_add: result = alu_a + alu_b;
			mips_pkg::alu_sub: result = alu_a - alu_b;
			mips_pkg::alu_slt: begin
				result = '0;
				result[0] = $signed(alu_a) < $signed(alu_b);
			end
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);
	assign alu_result = result;

	// beq subtracts, so equal operands give zero.
	assign branch_taken = ex_bus.ctrl.branch & zero;
	assign branch_target = ex_bus.next_pc + {ex_bus.ext_offset[29:0], 2'b00};

	assign mem_addr = result;
	assign mem_wdata = ex_bus.read_data_2;
	assign mem_read = ex_bus.ctrl.mem_read;
	assign mem_write = ex_bus.ctrl.mem_write;

	// writeback lands at the end of this cycle.
	assign wb_en = ex_bus.ctrl.reg_write;
	assign wb_addr = ex_bus.ctrl.reg_dest ? ex_bus.rd : ex_bus.rt;
	assign wb_data = ex_bus.ctrl.mem_to_reg ? load_data : result;

endmodule

//--- id_ex.sv
`timescale 1ns/1ps

module id_ex (
	input  logic  clk,
	input  logic  reset_n,
	id_ex_if.sink   dec_bus,
	id_ex_if.source ex_bus
);

	mips_pkg::ctrl_t ctrl_q;
	mips_pkg::word_t next_pc_q;
	mips_pkg::word_t read_data_1_q;
	mips_pkg::word_t read_data_2_q;
	mips_pkg::word_t ext_offset_q;
	mips_pkg::reg_addr_t rt_q;
	mips_pkg::reg_addr_t rd_q;

	// reset loads a bubble into the stage.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ctrl_q <= '0;
			next_pc_q <= '0;
			read_data_1_q <= '0;
			read_data_2_q <= '0;
			ext_offset_q <= '0;
			rt_q <= '0;
			rd_q <= '0;
		end else begin
			ctrl_q <= dec_bus.ctrl;
			next_pc_q <= dec_bus.next_pc;
			read_data_1_q <= dec_bus.read_data_1;
			read_data_2_q <= dec_bus.read_data_2;
			ext_offset_q <= dec_bus.ext_offset;
			rt_q <= dec_bus.rt;
			rd_q <= dec_bus.rd;
		end
	end

	assign ex_bus.ctrl = ctrl_q;
	assign ex_bus.next_pc = next_pc_q;
	assign ex_bus.read_data_1 = read_data_1_q;
	assign ex_bus.read_data_2 = read_data_2_q;
	assign ex_bus.ext_offset = ext_offset_q;
	assign ex_bus.rt = rt_q;
	assign ex_bus.rd = rd_q;

endmodule

//--- id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if;

	mips_pkg::ctrl_t ctrl;
	mips_pkg::word_t next_pc;
	mips_pkg::word_t read_data_1;
	mips_pkg::word_t read_data_2;
	mips_pkg::word_t ext_offset;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;

	modport source (
		output ctrl,
		output next_pc,
		output read_data_1,
		output read_data_2,
		output ext_offset,
		output rt,
		output rd
	);

	modport sink (
		input ctrl,
		input next_pc,
		input read_data_1,
		input read_data_2,
		input ext_offset,
		input rt,
		input rd
	);

endinterface

//--- mips_pkg.sv
package mips_pkg;

	localparam int word_width = 32;
	localparam int reg_addr_width = 5;

	typedef logic [word_width-1:0] word_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	// main opcodes, bits 31 to 26.
	localparam logic [5:0] op_rtype = 6'b000000;
	localparam logic [5:0] op_lw    = 6'b100011;
	localparam logic [5:0] op_sw    = 6'b101011;
	localparam logic [5:0] op_beq   = 6'b000100;

	// r-type funct codes, bits 5 to 0.
	localparam logic [5:0] fn_add = 6'b100000;
	localparam logic [5:0] fn_sub = 6'b100010;
	localparam logic [5:0] fn_and = 6'b100100;
	localparam logic [5:0] fn_or  = 6'b100101;
	localparam logic [5:0] fn_slt = 6'b101010;

	// aluop from the main control unit.
	typedef enum logic [1:0] {
		alu_op_add   = 2'b00,
		alu_op_sub   = 2'b01,
		alu_op_funct = 2'b10
	} alu_op_t;

	// operation select for the alu.
	typedef enum logic [2:0] {
		alu_and = 3'b000,
		alu_or  = 3'b001,
		alu_add = 3'b010,
		alu_sub = 3'b110,
		alu_slt = 3'b111
	} alu_ctrl_t;

	// all zero is a bubble.
	typedef struct packed {
		logic    reg_write;
		logic    mem_to_reg;
		logic    branch;
		logic    mem_read;
		logic    mem_write;
		logic    reg_dest;
		logic    alu_src;
		alu_op_t alu_op;
	} ctrl_t;

endpackage

//--- register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                clk,
	input  logic                reset_n,
	input  mips_pkg::reg_addr_t rs_addr,
	input  mips_pkg::reg_addr_t rt_addr,
	output mips_pkg::word_t     rs_data,
	output mips_pkg::word_t     rt_data,
	input  logic                wb_en,
	input  mips_pkg::reg_addr_t wb_addr,
	input  mips_pkg::word_t     wb_data
);

	mips_pkg::word_t regs [0:31];

	// register zero reads zero, a pending write is forwarded.
	function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
		mips_pkg::word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (wb_en && (wb_addr == addr)) begin
			value = wb_data;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && (wb_addr != '0)) begin
			regs[wb_addr] <= wb_data;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the datapath testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_datapath -f build.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "verilator compile failed with status $status"
	exit 1
fi

./obj_dir/Vtb_datapath > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int reset_cycles = 16
) (
	output logic clk,
	output logic reset_n
);

	// 8 ns period.
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// release on a falling edge, clear of the capture edge.
	initial begin
		reset_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	end

endmodule

//--- tb_datapath.sv
`timescale 1ns/1ps

module tb_datapath;

	localparam int reset_cycles = 16;
	localparam logic [31:0] seed = 32'ha273ab18;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic        alu_known;
		logic [31:0] exp_alu;
		logic        mem_read;
		logic        mem_write;
		logic        branch_taken;
	} row_t;

	logic clk;
	logic reset_n;
	logic [31:0] instr;
	logic [31:0] pc_plus4;
	logic [31:0] load_data;
	logic [31:0] alu_result;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic mem_read;
	logic mem_write;
	logic branch_taken;
	logic [31:0] branch_target;

	row_t rows[$];
	logic [31:0] model_alu[$];
	logic [31:0] model_wdata[$];
	logic [31:0] model_target[$];
	logic [31:0] shadow [0:31];
	int data_errors = 0;
	int flag_errors = 0;
	int rows_checked = 0;
	int cycle_count = 0;
	logic table_ready = 1'b0;

	tb_clock_gen #(.reset_cycles(reset_cycles)) u_clock_gen (.clk(clk), .reset_n(reset_n));

	datapath_top dut (
		.clk           (clk),
		.reset_n       (reset_n),
		.instr         (instr),
		.pc_plus4      (pc_plus4),
		.load_data     (load_data),
		.alu_result    (alu_result),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// data memory model.
	always_comb load_data = xorshift(mem_addr ^ seed);

	always @(posedge clk) cycle_count <= cycle_count + 1;

	function automatic logic [31:0] encode_rtype(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] funct);
		return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic add_row(input logic [31:0] ins, input logic known, input logic [31:0] alu,
			input logic mr, input logic mw, input logic bt);
		row_t r;
		r.instr = ins;
		r.pc = 32'h0040_0004 + 32'(4 * rows.size());
		r.alu_known = known;
		r.exp_alu = alu;
		r.mem_read = mr;
		r.mem_write = mw;
		r.branch_taken = bt;
		rows.push_back(r);
	endtask

	// sequential isa model, exact because the bypass removes every hazard.
	task automatic model_row(input int i);
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		ins = rows[i].instr;
		rs = ins[25:21];
		rt = ins[20:16];
		rd = ins[15:11];
		a = shadow[rs];
		b = shadow[rt];
		imm = {{16{ins[15]}}, ins[15:0]};
		res = '0;
		case (ins[31:26])
			mips_pkg::op_lw: begin
				res = a + imm;
				if (rt != '0) shadow[rt] = xorshift(res ^ seed);
			end
			mips_pkg::op_sw: res = a + imm;
			mips_pkg::op_beq: res = a - b;
			default: begin
				// the all-zero no-op falls through with a zero result.
				case (ins[5:0])
					mips_pkg::fn_add: res = a + b;
					mips_pkg::fn_sub: res = a - b;
					mips_pkg::fn_and: res = a & b;
					mips_pkg::fn_or:  res = a | b;
					mips_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:          res = '0;
				endcase
				if (ins != '0 && rd != '0) shadow[rd] = res;
			end
		endcase
		model_alu.push_back(res);
		model_wdata.push_back(b);
		model_target.push_back(rows[i].pc + 4 * imm);
	endtask

	task automatic check_row(input int i);
		logic [31:0] exp_alu;
		logic [5:0] op;
		exp_alu = rows[i].alu_known ? rows[i].exp_alu : model_alu[i];
		op = rows[i].instr[31:26];
		if (alu_result !== exp_alu) begin
			$display("ERR alu_result row %0d expected %h actual %h", i, exp_alu, alu_result);
			data_errors++;
		end
		if (mem_read !== rows[i].mem_read) begin
			$display("ERR mem_read row %0d expected %h actual %h", i, rows[i].mem_read, mem_read);
			flag_errors++;
		end
		if (mem_write !== rows[i].mem_write) begin
			$display("ERR mem_write row %0d expected %h actual %h", i, rows[i].mem_write,
				mem_write);
			flag_errors++;
		end
		if (branch_taken !== rows[i].branch_taken) begin
			$display("ERR branch_taken row %0d expected %h actual %h", i,
				rows[i].branch_taken, branch_taken);
			flag_errors++;
		end
		if ((op == mips_pkg::op_lw || op == mips_pkg::op_sw) && mem_addr !== model_alu[i]) begin
			$display("ERR mem_addr row %0d expected %h actual %h", i, model_alu[i], mem_addr);
			data_errors++;
		end
		if (op == mips_pkg::op_sw && mem_wdata !== model_wdata[i]) begin
			$display("ERR mem_wdata row %0d expected %h actual %h", i, model_wdata[i], mem_wdata);
			data_errors++;
		end
		if (op == mips_pkg::op_beq && branch_target !== model_target[i]) begin
			$display("ERR branch_target row %0d expected %h actual %h", i, model_target[i],
				branch_target);
			data_errors++;
		end
		rows_checked++;
	endtask

	initial begin
		instr = '0;
		pc_plus4 = '0;
		for (int r = 0; r < 32; r++) shadow[r] = '0;
		add_row(32'h0, 1, 32'h0, 0, 0, 0);
		add_row(32'h0, 1, 32'h0, 0, 0, 0);
		add_row(encode_itype(mips_pkg::op_lw, 0, 1, 16'h0010), 1, 32'h10, 1, 0, 0);
		add_row(encode_itype(mips_pkg::op_lw, 0, 2, 16'h0024), 1, 32'h24, 1, 0, 0);
		add_row(encode_itype(mips_pkg::op_lw, 0, 3, 16'h7ffc), 1, 32'h7ffc, 1, 0, 0);
		add_row(encode_itype(mips_pkg::op_lw, 0, 4, 16'hfff8), 1, 32'hfffffff8, 1, 0, 0);
		// dependent chain right behind each producer.
		add_row(encode_rtype(1, 2, 5, mips_pkg::fn_add), 0, 32'h0, 0, 0, 0);
		add_row(encode_rtype(5, 3, 6, mips_pkg::fn_sub), 0, 32'h0, 0, 0, 0);
		add_row(encode_rtype(6, 1, 7, mips_pkg::fn_and), 0, 32'h0, 0, 0, 0);
		add_row(encode_rtype(7, 4, 8, mips_pkg::fn_or), 0, 32'h0, 0, 0, 0);
		add_row(encode_rtype(1, 2, 9, mips_pkg::fn_slt), 0, 32'h0, 0, 0, 0);
		add_row(encode_rtype(2, 1, 10, mips_pkg::fn_slt), 0, 32'h0, 0, 0, 0);
		add_row(encode_itype(mips_pkg::op_lw, 0, 11, 16'h0040), 1, 32'h40, 1, 0, 0);
		add_row(encode_rtype(11, 11, 12, mips_pkg::fn_add), 0, 32'h0, 0, 0, 0);
		add_row(encode_itype(mips_pkg::op_sw, 1, 12, 16'h0008), 0, 32'h0, 0, 1, 0);
		add_row(encode_itype(mips_pkg::op_sw, 0, 5, 16'hfffc), 1, 32'hfffffffc, 0, 1, 0);
		add_row(encode_itype(mips_pkg::op_beq, 1, 1, 16'h0003), 1, 32'h0, 0, 0, 1);
		add_row(encode_itype(mips_pkg::op_beq, 1, 2, 16'hfffe), 0, 32'h0, 0, 0, 0);
		add_row(encode_itype(mips_pkg::op_beq, 0, 0, 16'hfff0), 1, 32'h0, 0, 0, 1);
		// write to register zero, then read it back at once.
		add_row(encode_rtype(1, 2, 0, mips_pkg::fn_add), 0, 32'h0, 0, 0, 0);
		add_row(encode_rtype(0, 0, 13, mips_pkg::fn_or), 1, 32'h0, 0, 0, 0);
		add_row(encode_rtype(0, 3, 14, mips_pkg::fn_add), 0, 32'h0, 0, 0, 0);
		add_row(32'h0, 1, 32'h0, 0, 0, 0);
		add_row(32'h0, 1, 32'h0, 0, 0, 0);
		for (int i = 0; i < rows.size(); i++) model_row(i);
		table_ready = 1'b1;
		@(posedge reset_n);
		// outputs of row k show up two falling edges after it is driven.
		for (int k = 0; k < rows.size() + 2; k++) begin
			@(negedge clk);
			if (k >= 2) check_row(k - 2);
			if (k < rows.size()) begin
				instr = rows[k].instr;
				pc_plus4 = rows[k].pc;
			end else begin
				instr = '0;
				pc_plus4 = '0;
			end
		end
		$display("rows checked %0d, data errors %0d, control errors %0d", rows_checked,
			data_errors, flag_errors);
		if (data_errors + flag_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		int limit;
		wait (table_ready);
		limit = reset_cycles + rows.size() + 20;
		wait (cycle_count >= limit);
		$display("timeout, the run did not finish within %0d cycles", limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
